// File: Bender.yml
package:
  name: tcp_tx

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tcp_tx_pkg.sv
      - hw/tcp_tx/tcp_opt_builder.sv
      - hw/tcp_tx/tcp_cks_calc.sv
      - hw/tcp_tx/tcp_tx_fsm.sv
      - hw/tcp_tx_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tcp_tx_asserts.sv
      - bench/tcp_tx_tb.sv

// File: bench/tcp_tx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_asserts (
  input logic                   clk,
  input logic                   rst,
  input logic                   meta_acc,
  input logic                   ipv4_rdy,
  input logic                   ipv4_acc,
  input tcp_tx_pkg::ipv4_strm_t ipv4_strm
);

  int fail_cnt = 0; // Failed assertion count

  // One acceptance strobe per segment
  meta_acc_pulse: assert property (@(posedge clk) disable iff (rst)
    meta_acc |=> !meta_acc)
    else begin
      fail_cnt++;
      $error("meta_acc high for two cycles in a row");
    end

  sof_needs_val: assert property (@(posedge clk) disable iff (rst)
    ipv4_strm.sof |-> ipv4_strm.val)
    else begin
      fail_cnt++;
      $error("sof without val on the IPv4 stream");
    end

  eof_needs_val: assert property (@(posedge clk) disable iff (rst)
    ipv4_strm.eof |-> ipv4_strm.val)
    else begin
      fail_cnt++;
      $error("eof without val on the IPv4 stream");
    end

  // Offer withdrawn once IPv4 takes it
  rdy_drops: assert property (@(posedge clk) disable iff (rst)
    ipv4_rdy && ipv4_acc |=> !ipv4_rdy)
    else begin
      fail_cnt++;
      $error("ipv4_rdy still high after ipv4_acc");
    end

endmodule

`default_nettype wire

// File: bench/tcp_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_defines.svh"

module tcp_tx_tb;
  import tcp_tx_pkg::*;

  localparam int num_segs   = 200;
  localparam int seg_budget = 200; // Longest segment needs about 170 cycles
  localparam int max_cycles = num_segs * seg_budget;

  logic        clk;
  logic        rst;
  tx_meta_t    meta;
  logic        meta_rdy;
  logic        meta_acc;
  logic        pld_req;
  pld_strm_t   pld;
  logic        tcp_done;
  logic        ipv4_rdy;
  logic        ipv4_acc;
  logic        ipv4_req;
  ipv4_strm_t  ipv4_strm;
  logic [15:0] ipv4_pld_len;
  logic        ipv4_done;

  integer      seed;
  int          errors;
  int          cycles = 0;
  tx_meta_t    seg;              // Segment under test kept after meta is scrambled
  logic [7:0]  pld_buf [0:63];
  logic [7:0]  exp_bytes [0:127];
  logic [7:0]  rx_bytes [0:127];
  int          exp_len;
  int          rx_cnt;
  int          sof_cnt;
  int          eof_pos;
  int          req_cycles;
  logic [15:0] exp_cks;

  tcp_tx_top i_tcp_tx_top (
    .clk          (clk),
    .rst          (rst),
    .meta         (meta),
    .meta_rdy     (meta_rdy),
    .meta_acc     (meta_acc),
    .pld_req      (pld_req),
    .pld          (pld),
    .tcp_done     (tcp_done),
    .ipv4_rdy     (ipv4_rdy),
    .ipv4_acc     (ipv4_acc),
    .ipv4_req     (ipv4_req),
    .ipv4_strm    (ipv4_strm),
    .ipv4_pld_len (ipv4_pld_len),
    .ipv4_done    (ipv4_done)
  );

  bind tcp_tx_fsm tcp_tx_asserts i_tcp_tx_asserts (
    .clk       (clk),
    .rst       (rst),
    .meta_acc  (meta_acc),
    .ipv4_rdy  (ipv4_rdy),
    .ipv4_acc  (ipv4_acc),
    .ipv4_strm (ipv4_strm)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the run hung waiting on the DUT", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic logic [15:0] fold16(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    while (t[31:16] != 16'd0) begin
      t = {16'd0, t[15:0]} + {16'd0, t[31:16]}; // End-around carry
    end
    return t[15:0];
  endfunction

  function automatic logic [31:0] pseudo_sum(input logic [15:0] tcp_len);
    logic [31:0] s;
    s = {16'd0, seg.src_ip[31:16]} + {16'd0, seg.src_ip[15:0]};
    s = s + {16'd0, seg.dst_ip[31:16]} + {16'd0, seg.dst_ip[15:0]};
    s = s + 32'(`TCP_PROTO) + {16'd0, tcp_len};
    return s;
  endfunction

  // Odd byte count pads the last word with zero
  function automatic logic [31:0] byte_sum(input logic from_rx, input int len);
    logic [31:0] s;
    logic [7:0]  hi;
    logic [7:0]  lo;
    int          k;
    s = '0;
    for (k = 0; k < len; k = k + 2) begin
      hi = from_rx ? rx_bytes[k] : exp_bytes[k];
      if (k + 1 < len) begin
        lo = from_rx ? rx_bytes[k + 1] : exp_bytes[k + 1];
      end else begin
        lo = 8'h00;
      end
      s = s + {16'd0, hi, lo};
    end
    return s;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic put_word(input int pos, input logic [31:0] w);
    exp_bytes[pos]     = w[31:24];
    exp_bytes[pos + 1] = w[23:16];
    exp_bytes[pos + 2] = w[15:8];
    exp_bytes[pos + 3] = w[7:0];
  endtask

  task automatic gen_segment(input int idx);
    logic [31:0] r;
    logic [31:0] sum;
    int          k;
    seg.src_ip   = rand32();
    seg.dst_ip   = rand32();
    r            = rand32();
    seg.ipv4_len = r[15:0];
    seg.hdr.src_port = r[31:16];
    r            = rand32();
    seg.hdr.dst_port = r[15:0];
    seg.hdr.wnd      = r[31:16];
    seg.hdr.seq_num  = rand32();
    seg.hdr.ack_num  = rand32();
    r            = rand32();
    seg.hdr.offset  = r[3:0];   // Junk that the DUT overwrites
    seg.hdr.rsvd    = r[6:4];
    seg.hdr.flags   = r[15:7];
    seg.hdr.urg_ptr = r[31:16];
    r            = rand32();
    seg.hdr.cks  = r[15:0];
    seg.opt.mss  = r[31:16];
    r            = rand32();
    seg.opt.wnd_shift = r[7:0];
    // First 16 segments walk every option combination
    {seg.opt.mss_pres, seg.opt.wnd_pres, seg.opt.sack_perm_pres, seg.opt.ts_pres} =
      (idx < 16) ? 4'(idx) : r[11:8];
    seg.opt.ts_val = rand32();
    seg.opt.ts_ecr = rand32();
    r            = rand32();
    seg.pld_len  = (idx % 20 == 3) ? 16'd0 : 16'(r % 65);
    sum = '0;
    for (k = 0; k < int'(seg.pld_len); k++) begin
      r          = rand32();
      pld_buf[k] = r[7:0];
    end
    for (k = 0; k < int'(seg.pld_len); k = k + 2) begin
      r   = (k + 1 < int'(seg.pld_len)) ? {24'd0, pld_buf[k + 1]} : 32'd0;
      sum = sum + {16'd0, pld_buf[k], r[7:0]};
    end
    seg.pld_cks = sum;
  endtask

  task automatic build_expected();
    int          n;
    int          k;
    logic [15:0] tcp_len;
    n = `TCP_MIN_HDR_BYTES;
    if (seg.opt.mss_pres) begin
      put_word(n, {8'd2, 8'd4, seg.opt.mss});
      n = n + 4;
    end
    if (seg.opt.wnd_pres) begin
      put_word(n, {8'd1, 8'd3, 8'd3, seg.opt.wnd_shift}); // NOP pads to a word
      n = n + 4;
    end
    if (seg.opt.sack_perm_pres) begin
      put_word(n, 32'h0101_0402);
      n = n + 4;
    end
    if (seg.opt.ts_pres) begin
      put_word(n, 32'h0101_080a);
      put_word(n + 4, seg.opt.ts_val);
      put_word(n + 8, seg.opt.ts_ecr);
      n = n + 12;
    end
    put_word(0, {seg.hdr.src_port, seg.hdr.dst_port});
    put_word(4, seg.hdr.seq_num);
    put_word(8, seg.hdr.ack_num);
    put_word(12, {4'(n / 4), 3'b000, seg.hdr.flags, seg.hdr.wnd});
    put_word(16, {16'h0000, seg.hdr.urg_ptr}); // Checksum zero while summing
    for (k = 0; k < int'(seg.pld_len); k++) begin
      exp_bytes[n + k] = pld_buf[k];
    end
    exp_len = n + int'(seg.pld_len);
    tcp_len = 16'(exp_len);
    exp_cks = ~fold16(pseudo_sum(tcp_len) + byte_sum(1'b0, exp_len));
    exp_bytes[16] = exp_cks[15:8];
    exp_bytes[17] = exp_cks[7:0];
  endtask

  task automatic send_segment();
    logic [31:0] r;
    logic        req_seen;
    logic        pld_started;
    logic        got_eof;
    int          pld_idx;
    @(negedge clk);
    meta     = seg;
    meta_rdy = 1'b1;
    @(negedge clk);
    while (!meta_acc) begin
      @(negedge clk);
    end
    meta_rdy = 1'b0;
    meta     = '0; // DUT works from its registered copy
    @(negedge clk);
    if (meta_acc) report_error("meta_acc stayed high for more than one cycle");
    while (!ipv4_rdy) begin
      @(negedge clk);
    end
    if (ipv4_pld_len !== 16'(exp_len)) begin
      report_mismatch("ipv4_pld_len", 32'(ipv4_pld_len), exp_len);
    end
    r = rand32();
    repeat (r[1:0]) begin
      @(negedge clk);
      if (!ipv4_rdy) report_error("ipv4_rdy dropped before ipv4_acc");
    end
    ipv4_acc = 1'b1;
    @(negedge clk);
    ipv4_acc = 1'b0;
    if (ipv4_rdy) report_error("ipv4_rdy still high in the cycle after ipv4_acc");
    rx_cnt      = 0;
    sof_cnt     = 0;
    eof_pos     = -1;
    req_cycles  = 0;
    req_seen    = 1'b0;
    pld_started = 1'b0;
    got_eof     = 1'b0;
    pld_idx     = 0;
    while (!got_eof) begin
      if (ipv4_strm.val) begin
        if (rx_cnt < 128) rx_bytes[rx_cnt] = ipv4_strm.dat;
        if (ipv4_strm.sof) sof_cnt++;
        if (ipv4_strm.eof) begin
          got_eof = 1'b1;
          eof_pos = rx_cnt;
        end
        rx_cnt++;
      end else if (ipv4_strm.sof || ipv4_strm.eof) begin
        report_error("sof or eof seen without val");
      end
      if (pld_req) req_cycles++;
      // Payload byte follows pld_req by one cycle
      if (req_seen) begin
        pld.dat = pld_buf[pld_idx];
        pld.val = 1'b1;
        pld_idx++;
      end else begin
        pld = '0;
      end
      pld_started = pld_started | pld_req;
      req_seen    = pld_req;
      r           = rand32();
      ipv4_req    = pld_started | (r[1:0] != 2'b00); // Stalls only in the header
      @(negedge clk);
    end
    ipv4_req = 1'b0;
  endtask

  task automatic check_segment(input int idx);
    int          k;
    int          words;
    logic [15:0] chk;
    words = int'(seg.opt.mss_pres) + int'(seg.opt.wnd_pres) +
            int'(seg.opt.sack_perm_pres) + 3 * int'(seg.opt.ts_pres);
    if (rx_cnt != exp_len) report_mismatch("streamed byte count", rx_cnt, exp_len);
    if (sof_cnt != 1) report_mismatch("sof count", sof_cnt, 1);
    if (eof_pos != exp_len - 1) report_mismatch("eof position", eof_pos, exp_len - 1);
    if (req_cycles != int'(seg.pld_len)) begin
      report_mismatch("pld_req cycles", req_cycles, 32'(seg.pld_len));
    end
    if (rx_cnt == exp_len) begin
      if (rx_bytes[12][7:4] !== 4'(5 + words)) begin
        report_mismatch("data offset", 32'(rx_bytes[12][7:4]), 5 + words);
      end
      for (k = 0; k < exp_len; k++) begin
        if (rx_bytes[k] !== exp_bytes[k]) begin
          report_mismatch($sformatf("segment %0d byte %0d", idx, k), 32'(rx_bytes[k]),
                          32'(exp_bytes[k]));
        end
      end
      chk = fold16(pseudo_sum(16'(rx_cnt)) + byte_sum(1'b1, rx_cnt));
      if (chk !== 16'hffff) report_mismatch("checksum verify sum", 32'(chk), 32'hffff);
    end
  endtask

  task automatic release_segment();
    logic [31:0] r;
    r = rand32();
    repeat (r[1:0]) begin
      if (ipv4_strm.val) report_error("stream kept sending after eof");
      if (tcp_done) report_error("tcp_done pulsed before ipv4_done");
      @(negedge clk);
    end
    ipv4_done = 1'b1;
    @(negedge clk);
    ipv4_done = 1'b0;
    if (!tcp_done) report_error("tcp_done did not pulse after ipv4_done");
    @(negedge clk);
    if (tcp_done) report_error("tcp_done stayed high for more than one cycle");
  endtask

  initial begin
    int seg_idx;
    seed      = 32'hf595_c1c3;
    errors    = 0;
    rst       = 1'b1;
    meta      = '0;
    meta_rdy  = 1'b0;
    pld       = '0;
    ipv4_acc  = 1'b0;
    ipv4_req  = 1'b0;
    ipv4_done = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (seg_idx = 0; seg_idx < num_segs; seg_idx++) begin
      gen_segment(seg_idx);
      build_expected();
      send_segment();
      check_segment(seg_idx);
      release_segment();
    end
    errors = errors + i_tcp_tx_top.i_tcp_tx_fsm.i_tcp_tx_asserts.fail_cnt;
    $display("Segments sent: %0d, errors: %0d", num_segs, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: common/tcp_tx_defines.svh
`ifndef TCP_TX_DEFINES_SVH
`define TCP_TX_DEFINES_SVH

// Base TCP header without options
`define TCP_MIN_HDR_BYTES 20

// Offset field caps the header at 15 words
`define TCP_MAX_HDR_BYTES 60

// MSS, window scale, SACK-permitted and three timestamp words
`define TCP_OPT_WORDS 6

// Protocol number placed in the pseudo header
`define TCP_PROTO 6

`endif

// File: common/tcp_tx_pkg.sv
`default_nettype none

`include "tcp_tx_defines.svh"

package tcp_tx_pkg;

  typedef logic [0:`TCP_MAX_HDR_BYTES-1][7:0] hdr_bytes_t; // Byte 0 goes out first

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [3:0]  offset;  // Rewritten from the option word count
    logic [2:0]  rsvd;
    logic [8:0]  flags;   // NS down to FIN
    logic [15:0] wnd;
    logic [15:0] cks;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        wnd_pres;
    logic [7:0]  wnd_shift;
    logic        sack_perm_pres;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_ecr;
  } tcp_opt_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] ipv4_len;
    tcp_hdr_t    hdr;
    tcp_opt_t    opt;
    logic [15:0] pld_len;
    logic [31:0] pld_cks; // Running sum of payload 16-bit words
  } tx_meta_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
  } pld_strm_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } ipv4_strm_t;

  typedef enum logic [2:0] {
    idle_s,
    opt_s,
    cks_s,
    rdy_s,
    hdr_s,
    pld_s,
    wait_s
  } tx_state_e;

  typedef enum logic [7:0] {
    opt_nop       = 8'd1,
    opt_mss       = 8'd2,
    opt_wnd       = 8'd3,
    opt_sack_perm = 8'd4,
    opt_ts        = 8'd8
  } opt_kind_e;

endpackage

`default_nettype wire

// File: compile.f
+incdir+common
common/tcp_tx_pkg.sv
hw/tcp_tx/tcp_opt_builder.sv
hw/tcp_tx/tcp_cks_calc.sv
hw/tcp_tx/tcp_tx_fsm.sv
hw/tcp_tx_top.sv
bench/tcp_tx_asserts.sv
bench/tcp_tx_tb.sv

// File: hw/tcp_tx/tcp_cks_calc.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_defines.svh"

module tcp_cks_calc (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cks_start,
  input  tcp_tx_pkg::hdr_bytes_t hdr_bytes,
  input  logic [4:0]             hdr_len_words,
  input  logic [31:0]            src_ip,
  input  logic [31:0]            dst_ip,
  input  logic [15:0]            tcp_len,
  input  logic [31:0]            pld_cks,
  output logic [15:0]            cks,
  output logic                   cks_done
);
  import tcp_tx_pkg::*;

  hdr_bytes_t       hdr_q;
  logic [0:11][7:0] pseudo_q; // Source IP, destination IP, zero, protocol, length
  logic [31:0]      acc_pseudo;
  logic [31:0]      acc_hdr;
  logic [31:0]      seed;
  logic [4:0]       len_q;
  logic [4:0]       cnt;
  logic             busy;
  logic [31:0]      total;
  logic [16:0]      fold_1;
  logic [15:0]      fold_2;

  assign total  = seed + acc_pseudo + acc_hdr;
  assign fold_1 = {1'b0, total[31:16]} + {1'b0, total[15:0]};
  assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]}; // Second fold absorbs the last carry

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      cnt      <= '0;
      cks_done <= 1'b0;
    end else begin
      cks_done <= 1'b0;
      if (cks_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 5'd1;
        if (cnt == len_q) begin // All header words summed
          busy     <= 1'b0;
          cks_done <= 1'b1;
        end
      end
    end
  end

  // Pseudo header is only 6 words, zeros shift in behind it
  always_ff @(posedge clk) begin
    if (cks_start) begin
      pseudo_q   <= {src_ip, dst_ip, 8'h00, 8'(`TCP_PROTO), tcp_len};
      hdr_q      <= hdr_bytes;
      len_q      <= hdr_len_words;
      seed       <= pld_cks;
      acc_pseudo <= '0;
      acc_hdr    <= '0;
    end else if (busy) begin
      pseudo_q <= {pseudo_q[2:11], 16'h0000};
      hdr_q    <= {hdr_q[2:`TCP_MAX_HDR_BYTES-1], 16'h0000};
      if (cnt < len_q) begin
        acc_pseudo <= acc_pseudo + {16'd0, pseudo_q[0:1]};
        acc_hdr    <= acc_hdr + {16'd0, hdr_q[0:1]};
      end
      if (cnt == len_q) cks <= ~fold_2;
    end
  end

endmodule

`default_nettype wire

// File: hw/tcp_tx/tcp_opt_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_defines.svh"

module tcp_opt_builder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 opt_start,
  input  tcp_tx_pkg::tcp_opt_t opt,
  output logic [0:`TCP_MAX_HDR_BYTES-`TCP_MIN_HDR_BYTES-1][7:0] opt_bytes,
  output logic [2:0]           opt_words,
  output logic                 opt_done
);
  import tcp_tx_pkg::*;

  logic [0:`TCP_OPT_WORDS-1][31:0] proto, proto_q, src_proto;
  logic [0:`TCP_OPT_WORDS-1]       pres, pres_q, src_pres;
  logic [0:`TCP_MAX_HDR_BYTES-`TCP_MIN_HDR_BYTES-1][7:0] base_bytes;
  logic [2:0] base_words;
  logic [2:0] cnt;
  logic       busy;

  // Last word pushed ends up first, so timestamp goes in before MSS
  always_comb begin
    proto[0] = opt.ts_ecr;
    proto[1] = opt.ts_val;
    proto[2] = {opt_nop, opt_nop, opt_ts, 8'd10};
    proto[3] = {opt_nop, opt_nop, opt_sack_perm, 8'd2};
    proto[4] = {opt_nop, opt_wnd, 8'd3, opt.wnd_shift};
    proto[5] = {opt_mss, 8'd4, opt.mss};
  end

  assign pres = {{3{opt.ts_pres}}, opt.sack_perm_pres, opt.wnd_pres, opt.mss_pres};

  // Start cycle handles word 0 straight from the prototypes
  assign src_proto  = opt_start ? proto : proto_q;
  assign src_pres   = opt_start ? pres : pres_q;
  assign base_bytes = opt_start ? '0 : opt_bytes;
  assign base_words = opt_start ? 3'd0 : opt_words;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      cnt      <= '0;
      opt_done <= 1'b0;
    end else begin
      opt_done <= 1'b0;
      if (opt_start) begin
        busy <= 1'b1;
        cnt  <= 3'd1;
      end else if (busy) begin
        cnt <= cnt + 3'd1;
        if (cnt == 3'(`TCP_OPT_WORDS - 1)) begin // Last prototype word
          busy     <= 1'b0;
          opt_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (opt_start || busy) begin
      proto_q <= {src_proto[1:`TCP_OPT_WORDS-1], 32'h0};
      pres_q  <= {src_pres[1:`TCP_OPT_WORDS-1], 1'b0};
      if (src_pres[0]) begin
        opt_bytes <= {src_proto[0], base_bytes[0:35]}; // Push present word at the front
        opt_words <= base_words + 3'd1;
      end else begin
        opt_bytes <= base_bytes;
        opt_words <= base_words;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/tcp_tx/tcp_tx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_defines.svh"

module tcp_tx_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  tcp_tx_pkg::tx_meta_t   meta,
  input  logic                   meta_rdy,
  output logic                   meta_acc,
  output logic                   pld_req,
  input  tcp_tx_pkg::pld_strm_t  pld,
  output logic                   ipv4_rdy,
  input  logic                   ipv4_acc,
  input  logic                   ipv4_req,
  output tcp_tx_pkg::ipv4_strm_t ipv4_strm,
  output logic [15:0]            ipv4_pld_len,
  input  logic                   ipv4_done,
  output logic                   tcp_done,
  output logic                   opt_start,
  output tcp_tx_pkg::tcp_opt_t   opt,
  input  logic [0:`TCP_MAX_HDR_BYTES-`TCP_MIN_HDR_BYTES-1][7:0] opt_bytes,
  input  logic [2:0]             opt_words,
  input  logic                   opt_done,
  output logic                   cks_start,
  output tcp_tx_pkg::hdr_bytes_t hdr_bytes,
  output logic [4:0]             hdr_len_words,
  output logic [31:0]            src_ip,
  output logic [31:0]            dst_ip,
  output logic [15:0]            tcp_len,
  output logic [31:0]            pld_cks,
  input  logic [15:0]            cks,
  input  logic                   cks_done
);
  import tcp_tx_pkg::*;

  tx_state_e  state;
  tx_meta_t   meta_q;
  tcp_hdr_t   hdr_fix;
  hdr_bytes_t tx_hdr;
  logic [0:`TCP_MAX_HDR_BYTES-`TCP_MIN_HDR_BYTES-1][7:0] opt_field;
  logic        done_q, fsm_rst;
  logic        has_opt, any_opt, accept;
  logic [3:0]  offset;
  logic [5:0]  hdr_len, hdr_cnt;
  logic        hdr_last, hdr_send;
  logic [15:0] pld_cnt, req_cnt;

  always_ff @(posedge clk) begin
    if (rst) done_q <= 1'b0;
    else     done_q <= ipv4_done;
  end

  assign fsm_rst  = rst | done_q; // Segment finished, start over
  assign tcp_done = done_q;

  assign any_opt = meta.opt.mss_pres | meta.opt.wnd_pres |
                   meta.opt.sack_perm_pres | meta.opt.ts_pres;
  assign accept  = (state == idle_s) && meta_rdy;

  assign offset        = 4'd5 + (has_opt ? {1'b0, opt_words} : 4'd0);
  assign hdr_len       = {offset, 2'b00};
  assign hdr_len_words = {offset, 1'b0};
  assign tcp_len       = {10'd0, hdr_len} + meta_q.pld_len;
  assign ipv4_pld_len  = tcp_len;
  assign src_ip        = meta_q.src_ip;
  assign dst_ip        = meta_q.dst_ip;
  assign pld_cks       = meta_q.pld_cks;
  assign opt           = meta_q.opt;
  assign opt_field     = has_opt ? opt_bytes : '0; // Builder output is stale without options

  always_comb begin
    hdr_fix        = meta_q.hdr;
    hdr_fix.offset = offset;
    hdr_fix.rsvd   = '0;
    hdr_fix.cks    = '0; // Zero while the checksum is summed
  end

  assign hdr_bytes = {hdr_fix, opt_field};

  // Once payload is requested the last header byte cannot wait
  assign hdr_last = (hdr_cnt == hdr_len - 6'd1);
  assign hdr_send = (state == hdr_s) && (ipv4_req || (pld_req && hdr_last));

  always_ff @(posedge clk) begin
    if (accept) meta_q <= meta;
    if (state == cks_s && cks_done) begin
      tx_hdr        <= hdr_bytes;
      tx_hdr[16:17] <= cks;
    end else if (hdr_send) begin
      tx_hdr <= {tx_hdr[1:`TCP_MAX_HDR_BYTES-1], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= idle_s;
      meta_acc  <= 1'b0;
      opt_start <= 1'b0;
      cks_start <= 1'b0;
      ipv4_rdy  <= 1'b0;
      ipv4_strm <= '0;
      pld_req   <= 1'b0;
      has_opt   <= 1'b0;
      hdr_cnt   <= '0;
      pld_cnt   <= '0;
      req_cnt   <= '0;
    end else begin
      meta_acc  <= 1'b0;
      opt_start <= 1'b0;
      cks_start <= 1'b0;
      if (pld_req) begin // Held for exactly pld_len cycles
        req_cnt <= req_cnt + 16'd1;
        if (req_cnt == meta_q.pld_len - 16'd1) pld_req <= 1'b0;
      end
      case (state)
        idle_s: begin
          if (accept) begin
            meta_acc <= 1'b1;
            has_opt  <= any_opt;
            if (any_opt) begin
              opt_start <= 1'b1;
              state     <= opt_s;
            end else begin
              cks_start <= 1'b1;
              state     <= cks_s;
            end
          end
        end
        opt_s: begin
          if (opt_done) begin
            cks_start <= 1'b1;
            state     <= cks_s;
          end
        end
        cks_s: begin
          if (cks_done) begin
            ipv4_rdy <= 1'b1;
            state    <= rdy_s;
          end
        end
        rdy_s: begin
          if (ipv4_acc) begin
            ipv4_rdy <= 1'b0;
            state    <= hdr_s;
          end
        end
        hdr_s: begin
          if (hdr_send) begin
            hdr_cnt       <= hdr_cnt + 6'd1;
            ipv4_strm.dat <= tx_hdr[0];
            ipv4_strm.val <= 1'b1;
            ipv4_strm.sof <= (hdr_cnt == 6'd0);
            ipv4_strm.eof <= hdr_last && (meta_q.pld_len == 16'd0);
            if (hdr_last) state <= (meta_q.pld_len == 16'd0) ? wait_s : pld_s;
          end else begin
            ipv4_strm.val <= 1'b0;
            ipv4_strm.sof <= 1'b0;
            ipv4_strm.eof <= 1'b0;
          end
          if (hdr_send && hdr_cnt == hdr_len - 6'd2 && meta_q.pld_len != 16'd0) begin
            pld_req <= 1'b1; // First payload byte lands right after the header
            req_cnt <= '0;
          end
        end
        pld_s: begin
          pld_cnt       <= pld_cnt + 16'd1;
          ipv4_strm.dat <= pld.dat;
          ipv4_strm.val <= pld.val;
          ipv4_strm.sof <= 1'b0;
          ipv4_strm.eof <= (pld_cnt == meta_q.pld_len - 16'd1);
          if (pld_cnt == meta_q.pld_len - 16'd1) state <= wait_s;
        end
        wait_s: begin
          ipv4_strm <= '0; // Idle until IPv4 reports done
        end
        default: state <= idle_s;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/tcp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_tx_defines.svh"

module tcp_tx_top (
  input  logic                   clk,
  input  logic                   rst,
  input  tcp_tx_pkg::tx_meta_t   meta,
  input  logic                   meta_rdy,
  output logic                   meta_acc,
  output logic                   pld_req,
  input  tcp_tx_pkg::pld_strm_t  pld,
  output logic                   tcp_done,
  output logic                   ipv4_rdy,
  input  logic                   ipv4_acc,
  input  logic                   ipv4_req,
  output tcp_tx_pkg::ipv4_strm_t ipv4_strm,
  output logic [15:0]            ipv4_pld_len,
  input  logic                   ipv4_done
);
  import tcp_tx_pkg::*;

  tcp_opt_t    opt;
  hdr_bytes_t  hdr_bytes;
  logic [0:`TCP_MAX_HDR_BYTES-`TCP_MIN_HDR_BYTES-1][7:0] opt_bytes;
  logic [2:0]  opt_words;
  logic        opt_start, opt_done;
  logic        cks_start, cks_done;
  logic [4:0]  hdr_len_words;
  logic [31:0] src_ip, dst_ip, pld_cks;
  logic [15:0] tcp_len, cks;

  tcp_opt_builder i_tcp_opt_builder (
    .clk       (clk),
    .rst       (rst),
    .opt_start (opt_start),
    .opt       (opt),
    .opt_bytes (opt_bytes),
    .opt_words (opt_words),
    .opt_done  (opt_done)
  );

  tcp_cks_calc i_tcp_cks_calc (
    .clk           (clk),
    .rst           (rst),
    .cks_start     (cks_start),
    .hdr_bytes     (hdr_bytes),
    .hdr_len_words (hdr_len_words),
    .src_ip        (src_ip),
    .dst_ip        (dst_ip),
    .tcp_len       (tcp_len),
    .pld_cks       (pld_cks),
    .cks           (cks),
    .cks_done      (cks_done)
  );

  tcp_tx_fsm i_tcp_tx_fsm (
    .clk           (clk),
    .rst           (rst),
    .meta          (meta),
    .meta_rdy      (meta_rdy),
    .meta_acc      (meta_acc),
    .pld_req       (pld_req),
    .pld           (pld),
    .ipv4_rdy      (ipv4_rdy),
    .ipv4_acc      (ipv4_acc),
    .ipv4_req      (ipv4_req),
    .ipv4_strm     (ipv4_strm),
    .ipv4_pld_len  (ipv4_pld_len),
    .ipv4_done     (ipv4_done),
    .tcp_done      (tcp_done),
    .opt_start     (opt_start),
    .opt           (opt),
    .opt_bytes     (opt_bytes),
    .opt_words     (opt_words),
    .opt_done      (opt_done),
    .cks_start     (cks_start),
    .hdr_bytes     (hdr_bytes),
    .hdr_len_words (hdr_len_words),
    .src_ip        (src_ip),
    .dst_ip        (dst_ip),
    .tcp_len       (tcp_len),
    .pld_cks       (pld_cks),
    .cks           (cks),
    .cks_done      (cks_done)
  );

endmodule

`default_nettype wire
